// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and scan the log for the failure line
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pow5_demo -f tb.f \
    && ./obj_dir/Vtb_pow5_demo > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not finish cleanly"; exit 1; }
echo "Simulation clean"
exit 0

// File: src/demo_control.sv
// Key synchronizer, handshake decode, operand counter, display assembly and status drive
`timescale 1ns/10ps
`default_nettype none

module demo_control import pow5_pkg::*; (
    input  logic        slow_clk,
    input  logic        rst,
    input  logic [3:0]  key_sw,
    input  logic        up_rdy,
    input  stream_t     down,
    output stream_t     up,
    output logic        down_rdy,
    output status_t     status,
    output display_t    disp
);

    // ------------------------------------------------------------------------
    // Key synchronizer
    // ------------------------------------------------------------------------

    // Keys are active low, so idle level is all ones
    logic [3:0] key_meta;
    logic [3:0] key_sync;

    // Two flops, reset to "nothing pressed"
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            key_meta <= 4'b1111;
            key_sync <= 4'b1111;
        end else begin
            key_meta <= key_sw;
            key_sync <= key_meta;
        end
    end

    // ------------------------------------------------------------------------
    // Operand counter
    // ------------------------------------------------------------------------

    logic [cnt_w-1:0] cnt;
    logic             up_xfer;

    // Upstream beat accepted on this edge
    assign up_xfer = up.vld && up_rdy;

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (up_xfer) begin
            // Wrap after the last operand
            if (cnt == cnt_w'(max_operand))
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Handshake decode and outputs
    // ------------------------------------------------------------------------

    always_comb begin
        // Either left key offers operands
        up.vld   = (key_sync[3:2] != 2'b11);
        up.data  = data_w'(cnt);
        // Ready by default, dropped by either right key
        down_rdy = (key_sync[1:0] == 2'b11);
    end

    // LED levels, inverted at the top
    always_comb begin
        status.up_vld   = up.vld;
        status.up_rdy   = up_rdy;
        status.down_vld = down.vld;
        status.down_rdy = down_rdy;
    end

    // Operand nibble on the left, 12-bit result on the right three digits
    always_comb begin
        disp.number = {up.data[3:0], down.data};
        disp.blank  = {~up_rdy, {3{~down.vld}}};
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Counter stays inside the operand range
    a_cnt_range: assert property (
        @(posedge slow_clk) disable iff (rst)
        cnt <= cnt_w'(max_operand)
    );

    // Offered operand held until the pipeline takes it
    a_up_hold: assert property (
        @(posedge slow_clk) disable iff (rst)
        (up.vld && !up_rdy) |=> $stable(up.data)
    );

endmodule

`default_nettype wire

// File: src/pow5_demo_top.sv
// Board top: control, fifth-power pipeline, display scanner and LED drive
`timescale 1ns/10ps
`default_nettype none

module pow5_demo_top import pow5_pkg::*; (
    input  logic       slow_clk,
    input  logic       rst,
    input  logic [3:0] key_sw,
    output logic [3:0] led,
    output logic [7:0] abcdefgh,
    output logic [3:0] digit
);

    // ------------------------------------------------------------------------
    // Interconnect
    // ------------------------------------------------------------------------

    stream_t  up;
    stream_t  down;
    logic     up_rdy;
    logic     down_rdy;
    status_t  status;
    display_t disp;

    // Keys, operand source, status and display content
    demo_control i_control (
        .slow_clk (slow_clk),
        .rst      (rst),
        .key_sw   (key_sw),
        .up_rdy   (up_rdy),
        .down     (down),
        .up       (up),
        .down_rdy (down_rdy),
        .status   (status),
        .disp     (disp)
    );

    // x^5 modulo 2^data_w
    pow5_pipeline i_pipeline (
        .slow_clk (slow_clk),
        .rst      (rst),
        .up       (up),
        .down_rdy (down_rdy),
        .up_rdy   (up_rdy),
        .down     (down)
    );

    // Time-multiplexed hex display
    seven_seg_scan i_display (
        .slow_clk (slow_clk),
        .rst      (rst),
        .disp     (disp),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // LEDs are active low, leftmost shows upstream valid
    assign led = ~{status.up_vld, status.up_rdy, status.down_vld, status.down_rdy};

endmodule

`default_nettype wire

// File: src/pow5_pipeline.sv
// Three-stage fifth-power pipeline with valid/ready on both sides and a shared stall
`timescale 1ns/10ps
`default_nettype none

module pow5_pipeline import pow5_pkg::*; (
    input  logic    slow_clk,
    input  logic    rst,
    input  stream_t up,
    input  logic    down_rdy,
    output logic    up_rdy,
    output stream_t down
);

    // ------------------------------------------------------------------------
    // Stage registers
    // ------------------------------------------------------------------------

    pipe_stage_t s1;
    pipe_stage_t s2;
    pipe_stage_t s3;

    // Whole pipe moves when the output slot is free or being taken
    logic advance;

    assign advance = !s3.vld || down_rdy;

    // Upstream ready is the shared advance, so only an output bubble is squeezed out
    assign up_rdy = advance;

    // ------------------------------------------------------------------------
    // Stage 1: keep x, form x^2
    // ------------------------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            s1 <= '0;
        end else if (advance) begin
            // Empty input slot turns into a bubble
            s1.vld <= up.vld;
            s1.x   <= up.data;
            s1.p   <= data_w'(up.data * up.data);
        end
    end

    // ------------------------------------------------------------------------
    // Stage 2: square again for x^4
    // ------------------------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            s2 <= '0;
        end else if (advance) begin
            s2.vld <= s1.vld;
            s2.x   <= s1.x;
            // Truncation at each step keeps the result modulo 2^data_w
            s2.p   <= data_w'(s1.p * s1.p);
        end
    end

    // ------------------------------------------------------------------------
    // Stage 3: one more x for x^5
    // ------------------------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            s3 <= '0;
        end else if (advance) begin
            s3.vld <= s2.vld;
            s3.x   <= s2.x;
            s3.p   <= data_w'(s2.p * s2.x);
        end
    end

    // Output beat straight from the last register
    always_comb begin
        down.vld  = s3.vld;
        down.data = s3.p;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Result held while downstream stalls
    a_down_hold: assert property (
        @(posedge slow_clk) disable iff (rst)
        (down.vld && !down_rdy) |=> $stable(down)
    );

endmodule

`default_nettype wire

// File: src/pow5_pkg.sv
// Shared widths, counter limit, scan divider, segment codes, stream and status structs, scan enum
`default_nettype none

package pow5_pkg;

    // ------------------------------------------------------------------------
    // Datapath sizing
    // ------------------------------------------------------------------------

    // Operand and result width, results wrap modulo 2^12
    localparam int data_w = 12;

    // Operand counter runs 0 .. max_operand then wraps
    localparam int max_operand = 5;
    localparam int cnt_w       = $clog2(max_operand + 1);

    // Each digit stays lit for 2^scan_div_w cycles
    localparam int scan_div_w = 2;

    // ------------------------------------------------------------------------
    // Seven-segment codes
    // ------------------------------------------------------------------------

    // Bit order abcdefgh, active low, h is the dot
    localparam logic [7:0] seg_blank = 8'b1111_1111;

    // Hex glyphs indexed by nibble, dot kept off
    localparam logic [15:0][7:0] seg_hex = {
        8'b0111_0001,   // F
        8'b0110_0001,   // E
        8'b1000_0101,   // d
        8'b0110_0011,   // C
        8'b1100_0001,   // b
        8'b0001_0001,   // A
        8'b0000_1001,   // 9
        8'b0000_0001,   // 8
        8'b0001_1111,   // 7
        8'b0100_0001,   // 6
        8'b0100_1001,   // 5
        8'b1001_1001,   // 4
        8'b0000_1101,   // 3
        8'b0010_0101,   // 2
        8'b1001_1111,   // 1
        8'b0000_0011    // 0
    };

    // ------------------------------------------------------------------------
    // Bundled signals
    // ------------------------------------------------------------------------

    // One beat of a valid/ready stream, ready travels separately
    typedef struct packed {
        logic              vld;
        logic [data_w-1:0] data;
    } stream_t;

    // Pipeline register: operand kept alongside the running power
    typedef struct packed {
        logic              vld;
        logic [data_w-1:0] x;
        logic [data_w-1:0] p;
    } pipe_stage_t;

    // Handshake levels, field order matches the LED order left to right
    typedef struct packed {
        logic up_vld;
        logic up_rdy;
        logic down_vld;
        logic down_rdy;
    } status_t;

    // What the display shows; blank bit 3 is the leftmost digit
    typedef struct packed {
        logic [15:0] number;
        logic [3:0]  blank;
    } display_t;

    // Scan state, leftmost digit first
    typedef enum logic [1:0] {
        DIG3,
        DIG2,
        DIG1,
        DIG0
    } digit_sel_e;

endpackage

`default_nettype wire

// File: src/seven_seg_scan.sv
// Four-digit seven-segment scanner with hex decode and per-digit blanking
`timescale 1ns/10ps
`default_nettype none

module seven_seg_scan import pow5_pkg::*; (
    input  logic       slow_clk,
    input  logic       rst,
    input  display_t   disp,
    output logic [7:0] abcdefgh,
    output logic [3:0] digit
);

    // ------------------------------------------------------------------------
    // Scan timing
    // ------------------------------------------------------------------------

    logic [scan_div_w-1:0] div_cnt;
    digit_sel_e            sel;
    digit_sel_e            sel_next;

    // Next digit in the fixed left-to-right order
    always_comb begin
        case (sel)
            DIG3:    sel_next = DIG2;
            DIG2:    sel_next = DIG1;
            DIG1:    sel_next = DIG0;
            default: sel_next = DIG3;
        endcase
    end

    // Digit changes when the divider rolls over
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            sel     <= DIG3;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (&div_cnt)
                sel <= sel_next;
        end
    end

    // ------------------------------------------------------------------------
    // Nibble select, decode and blanking
    // ------------------------------------------------------------------------

    logic [3:0] nibble;
    logic       blank;

    always_comb begin
        case (sel)
            DIG3: begin
                nibble = disp.number[15:12];
                blank  = disp.blank[3];
                digit  = 4'b0111;
            end
            DIG2: begin
                nibble = disp.number[11:8];
                blank  = disp.blank[2];
                digit  = 4'b1011;
            end
            DIG1: begin
                nibble = disp.number[7:4];
                blank  = disp.blank[1];
                digit  = 4'b1101;
            end
            default: begin
                nibble = disp.number[3:0];
                blank  = disp.blank[0];
                digit  = 4'b1110;
            end
        endcase
    end

    // Blanked digit shows all segments off, dot included
    assign abcdefgh = blank ? seg_blank : seg_hex[nibble];

    // Exactly one digit driven at any time
    a_digit_onehot: assert property (
        @(posedge slow_clk) disable iff (rst)
        $onehot(~digit)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
src/pow5_pkg.sv
src/demo_control.sv
src/pow5_pipeline.sv
src/seven_seg_scan.sv
src/pow5_demo_top.sv
testbench/tb_pow5_demo.sv

// File: testbench/tb_pow5_checks.svh
// Testbench helpers: LCG, fifth-power reference, segment decode, display reader, compare tasks
`ifndef TB_POW5_CHECKS_SVH
`define TB_POW5_CHECKS_SVH

// ---------------------------------------------------------------------------
// Stimulus and reference values
// ---------------------------------------------------------------------------

// Full-period 32-bit LCG, upper bits are the useful ones
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// x^5 with the modulus taken after every multiply
function automatic logic [data_w-1:0] pow5(input int x);
    int r;
    r = 1;
    repeat (5) r = (r * x) % (1 << data_w);
    return data_w'(r);
endfunction

// Active-low abcdefgh back to a hex value, 16 means blank, -1 means garbage
function automatic int seg_to_hex(input logic [7:0] seg);
    case (seg)
        8'b1111_1111: return 16;
        8'b0000_0011: return 0;
        8'b1001_1111: return 1;
        8'b0010_0101: return 2;
        8'b0000_1101: return 3;
        8'b1001_1001: return 4;
        8'b0100_1001: return 5;
        8'b0100_0001: return 6;
        8'b0001_1111: return 7;
        8'b0000_0001: return 8;
        8'b0000_1001: return 9;
        8'b0001_0001: return 10;
        8'b1100_0001: return 11;
        8'b0110_0011: return 12;
        8'b1000_0101: return 13;
        8'b0110_0001: return 14;
        8'b0111_0001: return 15;
        default:      return -1;
    endcase
endfunction

// ---------------------------------------------------------------------------
// Display sampler
// ---------------------------------------------------------------------------

// One full scan, leftmost digit first; blank digits read back as nibble 0
task automatic read_display(output display_t shown);
    logic [3:0] code;
    int         n;
    int         v;
    shown = '0;
    for (int k = 3; k >= 0; k--) begin
        code = ~(4'b0001 << k);
        n = 0;
        @(negedge slow_clk);
        // Each digit comes round within one scan of 16 cycles
        while (digit !== code) begin
            if (n == 20)
                fail_now($sformatf("Timeout waiting for digit %0d to light", k));
            n++;
            @(negedge slow_clk);
        end
        v = seg_to_hex(abcdefgh);
        if (v < 0)
            fail_now($sformatf("Unknown segment pattern %b on digit %0d", abcdefgh, k));
        if (v == 16)
            shown.blank[k] = 1'b1;
        else
            shown.number[k*4 +: 4] = 4'(v);
    end
endtask

// ---------------------------------------------------------------------------
// Compare tasks
// ---------------------------------------------------------------------------

task automatic check_status(input status_t act, input status_t exp);
    if (act !== exp)
        fail_now($sformatf("FAIL %0t status: got %b, expected %b", $time, act, exp));
endtask

task automatic check_data(input string name, input logic [data_w-1:0] act,
                          input logic [data_w-1:0] exp);
    if (act !== exp)
        fail_now($sformatf("FAIL %0t %s: got %0d, expected %0d", $time, name, act, exp));
endtask

task automatic check_display(input display_t act, input display_t exp);
    if (act !== exp)
        fail_now($sformatf("FAIL %0t display: got %h/%b, expected %h/%b",
                           $time, act.number, act.blank, exp.number, exp.blank));
endtask

`endif

// File: testbench/tb_pow5_demo.sv
// Testbench top: clock, reset, key stimulus table, cycle model and pass/fail report
`timescale 1ns/10ps
`default_nettype none

module tb_pow5_demo import pow5_pkg::*; ();

    logic       slow_clk;
    logic       rst;
    logic [3:0] key_sw;
    logic [3:0] led;
    logic [7:0] abcdefgh;
    logic [3:0] digit;

    pow5_demo_top uut (
        .slow_clk (slow_clk),
        .rst      (rst),
        .key_sw   (key_sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // 20 ns period
    always #10 slow_clk = ~slow_clk;

    // ------------------------------------------------------------------------
    // Failure exit and helpers
    // ------------------------------------------------------------------------

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    `include "tb_pow5_checks.svh"

    // ------------------------------------------------------------------------
    // Cycle model, state as it stands after the latest rising edge
    // ------------------------------------------------------------------------

    logic [3:0]        m_meta;
    logic [3:0]        m_sync;
    logic [2:0]        m_vld;      // bit 2 is the output stage
    int                m_cnt;
    int                pops;
    logic [data_w-1:0] m_q[$];     // results in flight, oldest first

    // Evaluated mid-cycle where the DUT outputs are settled
    always @(negedge slow_clk) begin : model
        logic uv;
        logic dr;
        logic dv;
        logic ur;
        if (rst) begin
            m_meta = 4'b1111;
            m_sync = 4'b1111;
            m_vld  = '0;
            m_cnt  = 0;
            pops   = 0;
            m_q.delete();
        end else begin
            uv = (m_sync[3:2] != 2'b11);
            dr = (m_sync[1:0] == 2'b11);
            dv = m_vld[2];
            // Pipe moves when the output is empty or taken
            ur = !dv || dr;
            check_status(status_t'(~led), status_t'({uv, ur, dv, dr}));
            if (dv && dr) begin
                if (m_q.size() == 0)
                    fail_now("Downstream transfer with no operand in flight");
                check_data("down.data", uut.down.data, m_q.pop_front());
                pops++;
            end
            if (ur)
                m_vld = {m_vld[1:0], uv};
            // Accepted operand: queue its result, step 0..5 with wrap
            if (uv && ur) begin
                m_q.push_back(pow5(m_cnt));
                m_cnt = (m_cnt == max_operand) ? 0 : m_cnt + 1;
            end
            m_sync = m_meta;
            m_meta = key_sw;
        end
    end

    // What the four digits should show for the current model state
    function automatic display_t expected_display();
        display_t e;
        logic     dr;
        logic     ur;
        dr = (m_sync[1:0] == 2'b11);
        ur = !m_vld[2] || dr;
        e.number = '0;
        e.blank  = {!ur, {3{!m_vld[2]}}};
        if (ur)
            e.number[15:12] = 4'(m_cnt);
        if (m_vld[2])
            e.number[11:0] = m_q[0];
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    // keys active low: [3:2] left keys, [1:0] right keys
    typedef struct packed {
        logic [3:0] keys;
        logic [7:0] hold;
        logic       check;
    } row_t;

    localparam int n_rows = 9;

    row_t rows [0:n_rows-1] = '{
        '{4'b1111, 8'd4,  1'b1},   // reset state on the display
        '{4'b0111, 8'd20, 1'b0},   // stream through two wraps
        '{4'b0110, 8'd12, 1'b1},   // back-pressure with a full pipe
        '{4'b0111, 8'd15, 1'b0},   // release, stream resumes
        '{4'b1111, 8'd12, 1'b1},   // upstream idle, queue drains
        '{4'b1110, 8'd8,  1'b1},   // right key on an empty pipe
        '{4'b1011, 8'd9,  1'b0},   // other left key
        '{4'b1101, 8'd10, 1'b1},   // other right key stalls
        '{4'b1111, 8'd10, 1'b1}    // drain again
    };

    // Drive one row, optionally read the display twice once it has settled
    task automatic apply_row(input row_t r);
        display_t exp_disp;
        display_t shown;
        @(posedge slow_clk);
        #1;
        key_sw = r.keys;
        repeat (r.hold) @(posedge slow_clk);
        #1;
        if (r.check) begin
            exp_disp = expected_display();
            repeat (2) begin
                read_display(shown);
                check_display(shown, exp_disp);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        row_t        rnd;
        logic [31:0] seed;
        int          wait_n;
        $timeformat(-9, 0, " ns", 0);
        slow_clk = 1'b0;
        rst      = 1'b1;
        key_sw   = 4'b1111;
        seed     = 32'ha345_b752;
        repeat (2) @(posedge slow_clk);
        #1;
        rst = 1'b0;
        // up_vld off, up_rdy on, down_vld off, down_rdy on
        check_status(status_t'(~led), status_t'(4'b0101));

        for (int i = 0; i < n_rows; i++)
            apply_row(rows[i]);

        // Random keys and hold times
        for (int i = 0; i < 40; i++) begin
            seed = lcg_next(seed);
            rnd.keys  = seed[31:28];
            rnd.hold  = 8'(seed[26:24]) + 8'd1;
            rnd.check = 1'b0;
            apply_row(rnd);
        end

        // Release everything and let the pipe empty
        @(posedge slow_clk);
        #1;
        key_sw = 4'b1111;
        wait_n = 0;
        while (m_q.size() != 0 || led[1] !== 1'b1) begin
            if (wait_n == 30)
                fail_now("Timeout waiting for the pipeline to drain");
            wait_n++;
            @(posedge slow_clk);
            #1;
        end
        apply_row('{4'b1111, 8'd4, 1'b1});
        if (pops < 30)
            fail_now($sformatf("Only %0d results reached the output", pops));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
